//--- design/mem_cfg_pkg.sv
/* Memory bridge configuration
   Address and data widths, memory depth and the word types shared by the bridge */
package mem_cfg_pkg;

  localparam int ADDR_W      = 32;
  localparam int DATA_W      = 32;
  localparam int STRB_W      = DATA_W / 8;
  // Byte offset inside one word
  localparam int OFFSET_BITS = 2;
  localparam int MEM_WORDS   = 256;
  localparam int WORD_ADDR_W = 8;

  typedef logic [ADDR_W-1:0]      addr_t;
  typedef logic [DATA_W-1:0]      word_t;
  typedef logic [STRB_W-1:0]      strb_t;
  typedef logic [WORD_ADDR_W-1:0] word_addr_t;

endpackage

//--- design/axi_resp_pkg.sv
/* AXI response codes and the port selector of the bridge */
package axi_resp_pkg;

  typedef logic [1:0] resp_t;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // Owner of a memory access
  typedef enum logic {
    PORT_LP = 1'b0,
    PORT_HP = 1'b1
  } port_sel_e;

endpackage

//--- design/mem_req_if.sv
/* Memory request bundle
   One offered access from a port and the grant returned by the access unit */
`timescale 1ns/1ps

interface mem_req_if;
  import mem_cfg_pkg::*;

  logic       req_valid;
  logic       req_write;
  word_addr_t req_addr;
  word_t      req_wdata;
  strb_t      req_strb;
  // Address was misaligned or out of range
  logic       req_err;
  logic       grant;

  modport requester (
    output req_valid, req_write, req_addr, req_wdata, req_strb, req_err,
    input  grant
  );

  modport server (
    input  req_valid, req_write, req_addr, req_wdata, req_strb, req_err,
    output grant
  );

endinterface

//--- design/port_decode.sv
/* Port decode stage
   Holds one write and one read request per port and offers one per cycle */
`timescale 1ns/1ps

module port_decode (
  input  logic               ACLK,
  input  logic               ARESETn,
  input  mem_cfg_pkg::addr_t awaddr_i,
  input  logic               awvalid_i,
  output logic               awready_o,
  input  mem_cfg_pkg::word_t wdata_i,
  input  mem_cfg_pkg::strb_t wstrb_i,
  input  logic               wvalid_i,
  output logic               wready_o,
  input  mem_cfg_pkg::addr_t araddr_i,
  input  logic               arvalid_i,
  output logic               arready_o,
  input  logic               wr_busy_i,
  input  logic               rd_busy_i,
  mem_req_if.requester       req
);
  import mem_cfg_pkg::*;

  logic       wr_full;
  word_addr_t wr_addr;
  word_t      wr_data;
  strb_t      wr_strb;
  logic       wr_err;
  logic       rd_full;
  word_addr_t rd_addr;
  logic       rd_err;
  logic       pref_read;
  logic       stall_q;
  logic       stall_write_q;
  logic       wr_accept;
  logic       rd_accept;
  logic       wr_offer;
  logic       rd_offer;
  logic       pick_write;

  // Misaligned, or beyond the last byte of the array
  function automatic logic addr_bad(addr_t a);
    return (|a[OFFSET_BITS-1:0]) || (a >= addr_t'(MEM_WORDS * STRB_W));
  endfunction

  function automatic word_addr_t word_index(addr_t a);
    return a[OFFSET_BITS +: WORD_ADDR_W];
  endfunction

  // ----------------------------------------------------------
  // Request capture
  // ----------------------------------------------------------
  // AW and W are taken together, only into an empty slot
  assign wr_accept = awvalid_i & wvalid_i & ~wr_full;
  assign awready_o = wr_accept;
  assign wready_o  = wr_accept;
  assign arready_o = ~rd_full;
  assign rd_accept = arvalid_i & ~rd_full;

  always_ff @(posedge ACLK or negedge ARESETn)
  begin
    if (!ARESETn)
    begin
      wr_full       <= 1'b0;
      rd_full       <= 1'b0;
      pref_read     <= 1'b0;
      stall_q       <= 1'b0;
      stall_write_q <= 1'b0;
    end
    else
    begin
      pref_read     <= ~pref_read;
      stall_q       <= req.req_valid & ~req.grant;
      stall_write_q <= pick_write;
      if (wr_accept)
        wr_full <= 1'b1;
      else if (req.grant && pick_write)
        wr_full <= 1'b0;
      if (rd_accept)
        rd_full <= 1'b1;
      else if (req.grant && !pick_write)
        rd_full <= 1'b0;
    end
  end

  always_ff @(posedge ACLK)
  begin
    if (wr_accept)
    begin
      wr_addr <= word_index(awaddr_i);
      wr_data <= wdata_i;
      wr_strb <= wstrb_i;
      wr_err  <= addr_bad(awaddr_i);
    end
    if (rd_accept)
    begin
      rd_addr <= word_index(araddr_i);
      rd_err  <= addr_bad(araddr_i);
    end
  end

  // ----------------------------------------------------------
  // Offer to the access unit
  // ----------------------------------------------------------
  assign wr_offer = wr_full & ~wr_busy_i;
  assign rd_offer = rd_full & ~rd_busy_i;

  // A refused request keeps its kind until it is granted
  assign pick_write = stall_q ? stall_write_q
                              : (wr_offer & (~pref_read | ~rd_offer));

  assign req.req_valid = wr_offer | rd_offer;
  assign req.req_write = pick_write;
  assign req.req_addr  = pick_write ? wr_addr : rd_addr;
  assign req.req_wdata = wr_data;
  assign req.req_strb  = wr_strb;
  assign req.req_err   = pick_write ? wr_err : rd_err;

endmodule

//--- design/mem_access_unit.sv
/* Memory access unit
   Fixed-priority arbiter, single-ported word array and completion routing */
`timescale 1ns/1ps

module mem_access_unit (
  input  logic               ACLK,
  input  logic               ARESETn,
  mem_req_if.server          hp_req,
  mem_req_if.server          lp_req,
  output logic               hp_wr_done_o,
  output logic               hp_rd_done_o,
  output logic               lp_wr_done_o,
  output logic               lp_rd_done_o,
  output logic               done_err_o,
  output mem_cfg_pkg::word_t rdata_o
);
  import mem_cfg_pkg::*;
  import axi_resp_pkg::*;

  logic       any_grant;
  logic       sel_write;
  word_addr_t sel_addr;
  word_t      sel_wdata;
  strb_t      sel_strb;
  logic       sel_err;
  logic       mem_cen_n;
  logic       mem_wen_n;
  word_t      mem_array [MEM_WORDS] = '{default: '0};
  word_t      rdata_q;
  logic       done_q;
  logic       done_write_q;
  logic       done_err_q;
  port_sel_e  dest_q;

  // hp wins whenever it offers
  assign hp_req.grant = hp_req.req_valid;
  assign lp_req.grant = lp_req.req_valid & ~hp_req.req_valid;
  assign any_grant    = hp_req.req_valid | lp_req.req_valid;

  always_comb
  begin
    if (hp_req.req_valid)
    begin
      sel_write = hp_req.req_write;
      sel_addr  = hp_req.req_addr;
      sel_wdata = hp_req.req_wdata;
      sel_strb  = hp_req.req_strb;
      sel_err   = hp_req.req_err;
    end
    else
    begin
      sel_write = lp_req.req_write;
      sel_addr  = lp_req.req_addr;
      sel_wdata = lp_req.req_wdata;
      sel_strb  = lp_req.req_strb;
      sel_err   = lp_req.req_err;
    end
  end

  // Error requests never enable the array
  assign mem_cen_n = ~(any_grant & ~sel_err);
  assign mem_wen_n = ~sel_write;

  always_ff @(posedge ACLK)
  begin
    if (!mem_cen_n && !mem_wen_n)
    begin
      for (int b = 0; b < STRB_W; b++)
      begin
        if (sel_strb[b])
          mem_array[sel_addr][8*b +: 8] <= sel_wdata[8*b +: 8];
      end
    end
    if (!mem_cen_n && mem_wen_n)
      rdata_q <= mem_array[sel_addr];
  end

  // Owner and kind of the access, one cycle behind the grant
  always_ff @(posedge ACLK or negedge ARESETn)
  begin
    if (!ARESETn)
    begin
      done_q       <= 1'b0;
      done_write_q <= 1'b0;
      done_err_q   <= 1'b0;
      dest_q       <= PORT_LP;
    end
    else
    begin
      done_q       <= any_grant;
      done_write_q <= sel_write;
      done_err_q   <= sel_err;
      dest_q       <= hp_req.req_valid ? PORT_HP : PORT_LP;
    end
  end

  assign hp_wr_done_o = done_q & done_write_q & (dest_q == PORT_HP);
  assign hp_rd_done_o = done_q & ~done_write_q & (dest_q == PORT_HP);
  assign lp_wr_done_o = done_q & done_write_q & (dest_q == PORT_LP);
  assign lp_rd_done_o = done_q & ~done_write_q & (dest_q == PORT_LP);
  assign done_err_o   = done_err_q;
  assign rdata_o      = rdata_q;

endmodule

//--- design/response_return.sv
/* Response return stage
   One-deep B and R holding registers with busy flags back to the decode stage */
`timescale 1ns/1ps

module response_return (
  input  logic                ACLK,
  input  logic                ARESETn,
  input  logic                wr_done_i,
  input  logic                rd_done_i,
  input  logic                done_err_i,
  input  mem_cfg_pkg::word_t  rdata_i,
  input  logic                granted_write_i,
  input  logic                granted_read_i,
  output axi_resp_pkg::resp_t bresp_o,
  output logic                bvalid_o,
  input  logic                bready_i,
  output mem_cfg_pkg::word_t  rdata_o,
  output axi_resp_pkg::resp_t rresp_o,
  output logic                rvalid_o,
  input  logic                rready_i,
  output logic                wr_busy_o,
  output logic                rd_busy_o
);
  import axi_resp_pkg::*;

  logic  b_hs;
  logic  r_hs;
  resp_t done_resp;

  assign b_hs      = bvalid_o & bready_i;
  assign r_hs      = rvalid_o & rready_i;
  assign done_resp = done_err_i ? RESP_SLVERR : RESP_OKAY;

  always_ff @(posedge ACLK or negedge ARESETn)
  begin
    if (!ARESETn)
    begin
      bvalid_o  <= 1'b0;
      rvalid_o  <= 1'b0;
      wr_busy_o <= 1'b0;
      rd_busy_o <= 1'b0;
    end
    else
    begin
      if (wr_done_i)
        bvalid_o <= 1'b1;
      else if (b_hs)
        bvalid_o <= 1'b0;
      if (rd_done_i)
        rvalid_o <= 1'b1;
      else if (r_hs)
        rvalid_o <= 1'b0;
      // Busy spans grant to handshake
      if (granted_write_i)
        wr_busy_o <= 1'b1;
      else if (b_hs)
        wr_busy_o <= 1'b0;
      if (granted_read_i)
        rd_busy_o <= 1'b1;
      else if (r_hs)
        rd_busy_o <= 1'b0;
    end
  end

  always_ff @(posedge ACLK)
  begin
    if (wr_done_i)
      bresp_o <= done_resp;
    if (rd_done_i)
    begin
      rresp_o <= done_resp;
      rdata_o <= rdata_i;
    end
  end

endmodule

//--- design/mem_bridge_top.sv
/* Two-port memory bridge
   High- and low-priority AXI-style slave ports sharing one word memory */
`timescale 1ns/1ps

module mem_bridge_top (
  input  logic                ACLK,
  input  logic                ARESETn,
  // ----------------------------------------------------------
  // High-priority port
  // ----------------------------------------------------------
  input  mem_cfg_pkg::addr_t  hp_awaddr_i,
  input  logic                hp_awvalid_i,
  output logic                hp_awready_o,
  input  mem_cfg_pkg::word_t  hp_wdata_i,
  input  mem_cfg_pkg::strb_t  hp_wstrb_i,
  input  logic                hp_wvalid_i,
  output logic                hp_wready_o,
  output axi_resp_pkg::resp_t hp_bresp_o,
  output logic                hp_bvalid_o,
  input  logic                hp_bready_i,
  input  mem_cfg_pkg::addr_t  hp_araddr_i,
  input  logic                hp_arvalid_i,
  output logic                hp_arready_o,
  output mem_cfg_pkg::word_t  hp_rdata_o,
  output axi_resp_pkg::resp_t hp_rresp_o,
  output logic                hp_rvalid_o,
  input  logic                hp_rready_i,
  // ----------------------------------------------------------
  // Low-priority port
  // ----------------------------------------------------------
  input  mem_cfg_pkg::addr_t  lp_awaddr_i,
  input  logic                lp_awvalid_i,
  output logic                lp_awready_o,
  input  mem_cfg_pkg::word_t  lp_wdata_i,
  input  mem_cfg_pkg::strb_t  lp_wstrb_i,
  input  logic                lp_wvalid_i,
  output logic                lp_wready_o,
  output axi_resp_pkg::resp_t lp_bresp_o,
  output logic                lp_bvalid_o,
  input  logic                lp_bready_i,
  input  mem_cfg_pkg::addr_t  lp_araddr_i,
  input  logic                lp_arvalid_i,
  output logic                lp_arready_o,
  output mem_cfg_pkg::word_t  lp_rdata_o,
  output axi_resp_pkg::resp_t lp_rresp_o,
  output logic                lp_rvalid_o,
  input  logic                lp_rready_i
);
  import mem_cfg_pkg::*;

  logic  hp_wr_busy;
  logic  hp_rd_busy;
  logic  lp_wr_busy;
  logic  lp_rd_busy;
  logic  hp_wr_done;
  logic  hp_rd_done;
  logic  lp_wr_done;
  logic  lp_rd_done;
  logic  done_err;
  word_t mem_rdata;

  mem_req_if hp_req ();
  mem_req_if lp_req ();

  port_decode u_hp_decode (
    .ACLK      (ACLK),
    .ARESETn   (ARESETn),
    .awaddr_i  (hp_awaddr_i), .awvalid_i (hp_awvalid_i), .awready_o (hp_awready_o),
    .wdata_i   (hp_wdata_i), .wstrb_i (hp_wstrb_i),
    .wvalid_i  (hp_wvalid_i), .wready_o (hp_wready_o),
    .araddr_i  (hp_araddr_i), .arvalid_i (hp_arvalid_i), .arready_o (hp_arready_o),
    .wr_busy_i (hp_wr_busy), .rd_busy_i (hp_rd_busy),
    .req       (hp_req)
  );

  port_decode u_lp_decode (
    .ACLK      (ACLK),
    .ARESETn   (ARESETn),
    .awaddr_i  (lp_awaddr_i), .awvalid_i (lp_awvalid_i), .awready_o (lp_awready_o),
    .wdata_i   (lp_wdata_i), .wstrb_i (lp_wstrb_i),
    .wvalid_i  (lp_wvalid_i), .wready_o (lp_wready_o),
    .araddr_i  (lp_araddr_i), .arvalid_i (lp_arvalid_i), .arready_o (lp_arready_o),
    .wr_busy_i (lp_wr_busy), .rd_busy_i (lp_rd_busy),
    .req       (lp_req)
  );

  mem_access_unit u_access (
    .ACLK         (ACLK),
    .ARESETn      (ARESETn),
    .hp_req       (hp_req),
    .lp_req       (lp_req),
    .hp_wr_done_o (hp_wr_done), .hp_rd_done_o (hp_rd_done),
    .lp_wr_done_o (lp_wr_done), .lp_rd_done_o (lp_rd_done),
    .done_err_o   (done_err),
    .rdata_o      (mem_rdata)
  );

  // Busy tracking follows the grant on each request bundle
  response_return u_hp_return (
    .ACLK            (ACLK),
    .ARESETn         (ARESETn),
    .wr_done_i       (hp_wr_done), .rd_done_i (hp_rd_done),
    .done_err_i      (done_err), .rdata_i (mem_rdata),
    .granted_write_i (hp_req.grant & hp_req.req_write),
    .granted_read_i  (hp_req.grant & ~hp_req.req_write),
    .bresp_o         (hp_bresp_o), .bvalid_o (hp_bvalid_o), .bready_i (hp_bready_i),
    .rdata_o         (hp_rdata_o), .rresp_o (hp_rresp_o),
    .rvalid_o        (hp_rvalid_o), .rready_i (hp_rready_i),
    .wr_busy_o       (hp_wr_busy), .rd_busy_o (hp_rd_busy)
  );

  response_return u_lp_return (
    .ACLK            (ACLK),
    .ARESETn         (ARESETn),
    .wr_done_i       (lp_wr_done), .rd_done_i (lp_rd_done),
    .done_err_i      (done_err), .rdata_i (mem_rdata),
    .granted_write_i (lp_req.grant & lp_req.req_write),
    .granted_read_i  (lp_req.grant & ~lp_req.req_write),
    .bresp_o         (lp_bresp_o), .bvalid_o (lp_bvalid_o), .bready_i (lp_bready_i),
    .rdata_o         (lp_rdata_o), .rresp_o (lp_rresp_o),
    .rvalid_o        (lp_rvalid_o), .rready_i (lp_rready_i),
    .wr_busy_o       (lp_wr_busy), .rd_busy_o (lp_rd_busy)
  );

endmodule

//--- bench/mem_access_chk.sv
/* Access unit assertions
   Arbitration, error gating and grant-to-done timing */
`timescale 1ns/1ps

module mem_access_chk (
  input logic       ACLK,
  input logic       ARESETn,
  input logic       hp_valid_i,
  input logic       hp_grant_i,
  input logic       lp_grant_i,
  input logic       hp_err_i,
  input logic       lp_err_i,
  input logic       mem_cen_n_i,
  input logic [3:0] done_vec_i
);

  a_one_grant: assert property (@(posedge ACLK) disable iff (!ARESETn)
    !(hp_grant_i && lp_grant_i))
    else $error("two grants in one cycle");

  a_hp_first: assert property (@(posedge ACLK) disable iff (!ARESETn)
    hp_valid_i |-> !lp_grant_i)
    else $error("lp granted while hp offers");

  // Error flag taken from the granted port, ahead of the request mux
  a_err_no_mem: assert property (@(posedge ACLK) disable iff (!ARESETn)
    ((hp_grant_i && hp_err_i) || (lp_grant_i && lp_err_i)) |-> mem_cen_n_i)
    else $error("memory enabled for an error request");

  // Done vector is hp write, hp read, lp write, lp read
  a_hp_done: assert property (@(posedge ACLK) disable iff (!ARESETn)
    hp_grant_i |=> ($onehot(done_vec_i) && (|done_vec_i[3:2])))
    else $error("hp grant not followed by exactly one hp done pulse");

  a_lp_done: assert property (@(posedge ACLK) disable iff (!ARESETn)
    lp_grant_i |=> ($onehot(done_vec_i) && (|done_vec_i[1:0])))
    else $error("lp grant not followed by exactly one lp done pulse");

  a_no_stray_done: assert property (@(posedge ACLK) disable iff (!ARESETn)
    !(hp_grant_i || lp_grant_i) |=> (done_vec_i == 4'b0000))
    else $error("done pulse without a grant");

endmodule

bind mem_access_unit mem_access_chk u_access_chk (
  .ACLK        (ACLK),
  .ARESETn     (ARESETn),
  .hp_valid_i  (hp_req.req_valid),
  .hp_grant_i  (hp_req.grant),
  .lp_grant_i  (lp_req.grant),
  .hp_err_i    (hp_req.req_err),
  .lp_err_i    (lp_req.req_err),
  .mem_cen_n_i (mem_cen_n),
  .done_vec_i  ({hp_wr_done_o, hp_rd_done_o, lp_wr_done_o, lp_rd_done_o})
);

//--- bench/tb_clock.sv
/* Testbench clock and reset
   100 ns clock, reset held low for the first 5 cycles */
`timescale 1ns/1ps

module tb_clock (
  output logic ACLK,
  output logic ARESETn
);

  initial
  begin
    ACLK    = 1'b0;
    ARESETn = 1'b0;
    repeat (5) @(posedge ACLK);
    ARESETn <= 1'b1;
  end

  always #50 ACLK = ~ACLK;

endmodule

//--- bench/tb_scoreboard.sv
/* Response scoreboard
   Compares B and R responses of both ports with the expected values in trace order */
`timescale 1ns/1ps

module tb_scoreboard (
  input logic                   ACLK,
  input logic                   ARESETn,
  input logic [1:0]             bvalid_i,
  input logic [1:0]             bready_i,
  input logic [1:0][1:0]        bresp_i,
  input logic [1:0]             rvalid_i,
  input logic [1:0]             rready_i,
  input logic [1:0][1:0]        rresp_i,
  input logic [1:0][31:0]       rdata_i
);

  // Entry layout is id, response, data
  logic [49:0] q_b0 [$];
  logic [49:0] q_b1 [$];
  logic [49:0] q_r0 [$];
  logic [49:0] q_r1 [$];
  int          b_count [2];
  int          r_count [2];
  int          b_rise [2];
  int          err_count;
  int          ok_count;
  int          cycle;
  logic [1:0]        prev_bvalid;
  logic [1:0]        prev_rvalid;
  logic [1:0]        prev_rready;
  logic [1:0][31:0]  prev_rdata;

  initial
  begin
    b_count     = '{0, 0};
    r_count     = '{0, 0};
    b_rise      = '{0, 0};
    err_count   = 0;
    ok_count    = 0;
    cycle       = 0;
    prev_bvalid = '0;
    prev_rvalid = '0;
    prev_rready = '1;
    prev_rdata  = '0;
  end

  task automatic push_expect(input int p, input bit is_read, input int id,
                             input logic [1:0] resp, input logic [31:0] data);
    logic [49:0] e;
    e = {id[15:0], resp, data};
    if (is_read && p == 1)
      q_r1.push_back(e);
    else if (is_read)
      q_r0.push_back(e);
    else if (p == 1)
      q_b1.push_back(e);
    else
      q_b0.push_back(e);
  endtask

  function automatic int pending();
    return q_b0.size() + q_b1.size() + q_r0.size() + q_r1.size();
  endfunction

  task automatic check_b(input int p);
    logic [49:0] e;
    string       name;
    name = (p == 1) ? "hp" : "lp";
    if ((p == 1 && q_b1.size() == 0) || (p == 0 && q_b0.size() == 0))
    begin
      $display("%s write response arrived while none was expected", name);
      err_count++;
    end
    else
    begin
      if (p == 1)
        e = q_b1.pop_front();
      else
        e = q_b0.pop_front();
      if (bresp_i[p] !== e[33:32])
      begin
        $display("CHECK FAILED %s_bresp_o got %h expected %h", name, bresp_i[p], e[33:32]);
        $display("op %0d %s write: mismatch", e[49:34], name);
        err_count++;
      end
      else
      begin
        $display("op %0d %s write: ok", e[49:34], name);
        ok_count++;
      end
    end
  endtask

  task automatic check_r(input int p);
    logic [49:0] e;
    string       name;
    bit          bad;
    name = (p == 1) ? "hp" : "lp";
    bad  = 1'b0;
    if ((p == 1 && q_r1.size() == 0) || (p == 0 && q_r0.size() == 0))
    begin
      $display("%s read response arrived while none was expected", name);
      err_count++;
    end
    else
    begin
      if (p == 1)
        e = q_r1.pop_front();
      else
        e = q_r0.pop_front();
      if (rresp_i[p] !== e[33:32])
      begin
        $display("CHECK FAILED %s_rresp_o got %h expected %h", name, rresp_i[p], e[33:32]);
        bad = 1'b1;
      end
      // Read data carries no meaning on an error response
      if (e[33:32] == axi_resp_pkg::RESP_OKAY && rdata_i[p] !== e[31:0])
      begin
        $display("CHECK FAILED %s_rdata_o got %h expected %h", name, rdata_i[p], e[31:0]);
        bad = 1'b1;
      end
      if (bad)
      begin
        $display("op %0d %s read: mismatch", e[49:34], name);
        err_count++;
      end
      else
      begin
        $display("op %0d %s read: ok", e[49:34], name);
        ok_count++;
      end
    end
  endtask

  // hp write response must rise before the lp one
  task automatic check_b_order();
    if (b_rise[1] >= b_rise[0])
    begin
      $display("hp write response did not arrive before the lp write response");
      err_count++;
    end
    else
    begin
      $display("write priority order: ok");
      ok_count++;
    end
  endtask

  task automatic print_summary();
    $display("%0d checks ok, %0d errors", ok_count, err_count);
  endtask

  // ------------------------------------------------------------
  // Monitor, sampled at the falling edge
  // ------------------------------------------------------------
  always @(negedge ACLK)
  begin
    if (ARESETn)
    begin
      cycle++;
      for (int p = 0; p < 2; p++)
      begin
        if (bvalid_i[p] && !prev_bvalid[p])
          b_rise[p] = cycle;
        if (prev_rvalid[p] && !prev_rready[p])
        begin
          if (!rvalid_i[p])
          begin
            $display("port %0d dropped rvalid before the handshake", p);
            err_count++;
          end
          else if (rdata_i[p] !== prev_rdata[p])
          begin
            $display("CHECK FAILED %s_rdata_o got %h expected %h",
                     (p == 1) ? "hp" : "lp", rdata_i[p], prev_rdata[p]);
            err_count++;
          end
        end
        if (bvalid_i[p] && bready_i[p])
        begin
          check_b(p);
          b_count[p]++;
        end
        if (rvalid_i[p] && rready_i[p])
        begin
          check_r(p);
          r_count[p]++;
        end
      end
      prev_bvalid = bvalid_i;
      prev_rvalid = rvalid_i;
      prev_rready = rready_i;
      prev_rdata  = rdata_i;
    end
  end

endmodule

//--- bench/tb_top.sv
/* Memory bridge testbench
   Replays the operation trace on both ports and hands expected responses to the scoreboard */
`timescale 1ns/1ps

module tb_top;
  import mem_cfg_pkg::*;
  import axi_resp_pkg::*;

  localparam int WAIT_LIMIT = 100;

  logic ACLK;
  logic ARESETn;

  // Index 1 is the hp port, index 0 the lp port
  logic [1:0] awvalid;
  logic [1:0] wvalid;
  logic [1:0] bready;
  logic [1:0] arvalid;
  logic [1:0] rready;
  addr_t      awaddr [2];
  word_t      wdata [2];
  strb_t      wstrb [2];
  addr_t      araddr [2];

  wire [1:0]              awready;
  wire [1:0]              wready;
  wire [1:0]              arready;
  wire [1:0]              bvalid;
  wire [1:0]              rvalid;
  wire [1:0][1:0]         bresp;
  wire [1:0][1:0]         rresp;
  wire [1:0][DATA_W-1:0]  rdata;

  tb_clock u_clock (
    .ACLK    (ACLK),
    .ARESETn (ARESETn)
  );

  mem_bridge_top dut (
    .ACLK         (ACLK),
    .ARESETn      (ARESETn),
    .hp_awaddr_i  (awaddr[1]),
    .hp_awvalid_i (awvalid[1]),
    .hp_awready_o (awready[1]),
    .hp_wdata_i   (wdata[1]),
    .hp_wstrb_i   (wstrb[1]),
    .hp_wvalid_i  (wvalid[1]),
    .hp_wready_o  (wready[1]),
    .hp_bresp_o   (bresp[1]),
    .hp_bvalid_o  (bvalid[1]),
    .hp_bready_i  (bready[1]),
    .hp_araddr_i  (araddr[1]),
    .hp_arvalid_i (arvalid[1]),
    .hp_arready_o (arready[1]),
    .hp_rdata_o   (rdata[1]),
    .hp_rresp_o   (rresp[1]),
    .hp_rvalid_o  (rvalid[1]),
    .hp_rready_i  (rready[1]),
    .lp_awaddr_i  (awaddr[0]),
    .lp_awvalid_i (awvalid[0]),
    .lp_awready_o (awready[0]),
    .lp_wdata_i   (wdata[0]),
    .lp_wstrb_i   (wstrb[0]),
    .lp_wvalid_i  (wvalid[0]),
    .lp_wready_o  (wready[0]),
    .lp_bresp_o   (bresp[0]),
    .lp_bvalid_o  (bvalid[0]),
    .lp_bready_i  (bready[0]),
    .lp_araddr_i  (araddr[0]),
    .lp_arvalid_i (arvalid[0]),
    .lp_arready_o (arready[0]),
    .lp_rdata_o   (rdata[0]),
    .lp_rresp_o   (rresp[0]),
    .lp_rvalid_o  (rvalid[0]),
    .lp_rready_i  (rready[0])
  );

  tb_scoreboard sb (
    .ACLK     (ACLK),
    .ARESETn  (ARESETn),
    .bvalid_i (bvalid),
    .bready_i (bready),
    .bresp_i  (bresp),
    .rvalid_i (rvalid),
    .rready_i (rready),
    .rresp_i  (rresp),
    .rdata_i  (rdata)
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("test failed");
    $finish;
  endtask

  // ------------------------------------------------------------
  // Handshake helpers
  // ------------------------------------------------------------
  task automatic issue_op(input int p, input bit is_read, input addr_t addr,
                          input word_t data, input strb_t strb);
    int  n;
    bit  ready_now;
    n = 0;
    @(posedge ACLK);
    if (is_read)
    begin
      araddr[p]  <= addr;
      arvalid[p] <= 1'b1;
    end
    else
    begin
      awaddr[p]  <= addr;
      wdata[p]   <= data;
      wstrb[p]   <= strb;
      awvalid[p] <= 1'b1;
      wvalid[p]  <= 1'b1;
    end
    // Ready seen at the falling edge means the transfer happens on the next rising edge
    @(negedge ACLK);
    ready_now = is_read ? arready[p] : (awready[p] & wready[p]);
    while (!ready_now)
    begin
      n++;
      if (n > WAIT_LIMIT)
        abort_run("timeout waiting for an address ready");
      @(negedge ACLK);
      ready_now = is_read ? arready[p] : (awready[p] & wready[p]);
    end
    @(posedge ACLK);
    arvalid[p] <= 1'b0;
    awvalid[p] <= 1'b0;
    wvalid[p]  <= 1'b0;
  endtask

  // Scoreboard counts move at the falling edge, so they are read at the rising one
  task automatic wait_done(input int p, input bit is_read, input int target);
    int n;
    n = 0;
    @(posedge ACLK);
    while ((is_read ? sb.r_count[p] : sb.b_count[p]) < target)
    begin
      n++;
      if (n > WAIT_LIMIT)
        abort_run("timeout waiting for a response handshake");
      @(posedge ACLK);
    end
  endtask

  task automatic wait_rvalid(input int p);
    int n;
    n = 0;
    @(negedge ACLK);
    while (!rvalid[p])
    begin
      n++;
      if (n > WAIT_LIMIT)
        abort_run("timeout waiting for a held read to become valid");
      @(negedge ACLK);
    end
  endtask

  // ------------------------------------------------------------
  // Trace replay
  // ------------------------------------------------------------
  initial
  begin
    int    fd;
    int    code;
    int    n;
    int    id;
    int    target;
    int    target_lp;
    int    held_target;
    int    mode;
    int    port;
    int    op;
    int    pend_port;
    bit    has_pend;
    string line;
    addr_t addr;
    addr_t pend_addr;
    word_t data;
    word_t pend_data;
    word_t exp_data;
    strb_t strb;
    strb_t pend_strb;
    resp_t resp;
    resp_t pend_resp;

    awvalid = '0;
    wvalid  = '0;
    arvalid = '0;
    bready  = 2'b11;
    rready  = 2'b11;
    for (int p = 0; p < 2; p++)
    begin
      awaddr[p] = '0;
      wdata[p]  = '0;
      wstrb[p]  = '0;
      araddr[p] = '0;
    end
    id          = 0;
    has_pend    = 1'b0;
    held_target = 0;

    fd = $fopen("bench/bridge_trace.txt", "r");
    if (fd == 0)
      abort_run("cannot open the trace file");

    n = 0;
    @(negedge ACLK);
    while (!ARESETn)
    begin
      n++;
      if (n > WAIT_LIMIT)
        abort_run("reset never released");
      @(negedge ACLK);
    end

    while (!$feof(fd))
    begin
      code = $fgets(line, fd);
      if (code > 0 && line.len() > 0 && line[0] != "#")
      begin
        code = $sscanf(line, "%d %d %d %h %h %h %h %h",
                       mode, port, op, addr, data, strb, resp, exp_data);
        if (code == 8)
        begin
          id++;
          if (has_pend)
          begin
            // Two writes presented in the same cycle
            has_pend  = 1'b0;
            target    = sb.b_count[pend_port] + 1;
            target_lp = sb.b_count[port] + 1;
            sb.push_expect(pend_port, 1'b0, id - 1, pend_resp, '0);
            sb.push_expect(port, 1'b0, id, resp, '0);
            fork
              issue_op(pend_port, 1'b0, pend_addr, pend_data, pend_strb);
              issue_op(port, 1'b0, addr, data, strb);
            join
            wait_done(pend_port, 1'b0, target);
            wait_done(port, 1'b0, target_lp);
            sb.check_b_order();
          end
          else if (mode == 1)
          begin
            has_pend  = 1'b1;
            pend_port = port;
            pend_addr = addr;
            pend_data = data;
            pend_strb = strb;
            pend_resp = resp;
          end
          else if (mode == 2)
          begin
            @(posedge ACLK);
            rready[port] <= 1'b0;
            held_target = sb.r_count[port] + 1;
            sb.push_expect(port, 1'b1, id, resp, exp_data);
            issue_op(port, 1'b1, addr, data, strb);
            wait_rvalid(port);
          end
          else if (mode == 3)
          begin
            @(posedge ACLK);
            rready[port] <= 1'b1;
            wait_done(port, 1'b1, held_target);
          end
          else
          begin
            target = (op == 1) ? sb.r_count[port] + 1 : sb.b_count[port] + 1;
            sb.push_expect(port, op == 1, id, resp, exp_data);
            issue_op(port, op == 1, addr, data, strb);
            wait_done(port, op == 1, target);
          end
        end
      end
    end
    $fclose(fd);

    repeat (5) @(posedge ACLK);
    sb.print_summary();
    if (sb.err_count == 0 && sb.pending() == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

//--- bench/bridge_trace.txt
# mode port(1 hp, 0 lp) op(0 write, 1 read) addr data strb resp expected_rdata
# mode 0 single, 1 paired with next line, 2 read with rready held, 3 release held read
0 1 0 00000010 11223344 f 0 00000000
0 1 1 00000010 00000000 0 0 11223344
0 0 0 00000020 aabbccdd f 0 00000000
0 0 1 00000020 00000000 0 0 aabbccdd
0 0 0 00000020 00005500 2 0 00000000
0 0 1 00000020 00000000 0 0 aabb55dd
1 1 0 00000040 01010101 f 0 00000000
0 0 0 00000044 02020202 f 0 00000000
0 0 1 00000044 00000000 0 0 02020202
0 1 0 00000400 deadbeef f 2 00000000
0 1 0 00000012 deadbeef f 2 00000000
0 1 1 00000010 00000000 0 0 11223344
0 0 1 00000400 00000000 0 2 00000000
2 1 1 00000040 00000000 0 0 01010101
0 1 0 00000048 cafef00d f 0 00000000
0 0 1 00000010 00000000 0 0 11223344
3 1 1 00000000 00000000 0 0 00000000
0 1 1 00000048 00000000 0 0 cafef00d

//--- tb.f
design/mem_cfg_pkg.sv
design/axi_resp_pkg.sv
design/mem_req_if.sv
design/port_decode.sv
design/mem_access_unit.sv
design/response_return.sv
design/mem_bridge_top.sv
bench/mem_access_chk.sv
bench/tb_clock.sv
bench/tb_scoreboard.sv
bench/tb_top.sv

//--- run.sh
#!/bin/sh
# Builds the memory bridge testbench with Verilator and runs it
set -e

verilator --binary --timing --assert --top-module tb_top -f tb.f -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -q "^test passed$"; then
  exit 0
else
  exit 1
fi
